/* compile.f */
logic/rv_decode_pkg.sv
logic/inst_classify.sv
logic/imm_gen.sv
logic/decode_hs_reg.sv
logic/decode_stage.sv
tests/tb_decode_stage.sv

/* logic/decode_hs_reg.sv */
// four-phase req/ack capture register for the decode results
// one item in flight; outputs hold from capture until the next capture
// reset drops ack_o and clears all outputs, which reads as GRP_NONE
`timescale 1ns/1ps

module decode_hs_reg (
    input  logic                                 clk,
    input  logic                                 rst_i,
    input  logic                                 req_i,
    input  rv_decode_pkg::dec_info_u             dec_info_i,
    input  logic [rv_decode_pkg::INST_W-1:0]     imm_i,
    input  logic [rv_decode_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [rv_decode_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    input  logic [rv_decode_pkg::REG_ADDR_W-1:0] rd_addr_i,
    input  logic                                 rd_we_i,
    output logic                                 ack_o,
    output rv_decode_pkg::dec_info_u             dec_info_o,
    output logic [rv_decode_pkg::INST_W-1:0]     imm_o,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] rd_addr_o,
    output logic                                 rd_we_o
);

    // IDLE waits for req, HELD waits for req to drop
    typedef enum logic {
        HS_IDLE,
        HS_HELD
    } hs_state_e;

    hs_state_e state;
    logic      capture;

    // first edge with req high while ack low
    assign capture = (state == HS_IDLE) & req_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state <= HS_IDLE;
        end else begin
            case (state)
                HS_IDLE: begin
                    if (req_i) begin
                        state <= HS_HELD;
                    end
                end
                HS_HELD: begin
                    // stays held while the requester keeps req high
                    if (!req_i) begin
                        state <= HS_IDLE;
                    end
                end
                default: state <= HS_IDLE;
            endcase
        end
    end

    // ack straight from the state flop
    assign ack_o = (state == HS_HELD);

    // result register, loads only on IDLE -> HELD
    always_ff @(posedge clk) begin
        if (rst_i) begin
            dec_info_o <= '0;
            imm_o      <= '0;
            rs1_addr_o <= '0;
            rs2_addr_o <= '0;
            rd_addr_o  <= '0;
            rd_we_o    <= 1'b0;
        end else if (capture) begin
            dec_info_o <= dec_info_i;
            imm_o      <= imm_i;
            rs1_addr_o <= rs1_addr_i;
            rs2_addr_o <= rs2_addr_i;
            rd_addr_o  <= rd_addr_i;
            rd_we_o    <= rd_we_i;
        end
    end

endmodule

/* logic/decode_stage.sv */
// registered RV32I decode stage with a four-phase req/ack input
// inst_i must stay stable from req_i rise until ack_o rises
// results valid while ack_o is high and held until the next capture
`timescale 1ns/1ps

module decode_stage (
    input  logic                                 clk,
    input  logic                                 rst_i,
    input  logic                                 req_i,
    input  logic [rv_decode_pkg::INST_W-1:0]     inst_i,
    output logic                                 ack_o,
    output rv_decode_pkg::dec_info_u             dec_info_o,
    output logic [rv_decode_pkg::INST_W-1:0]     imm_o,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] rd_addr_o,
    output logic                                 rd_we_o
);
    import rv_decode_pkg::*;

    // combinational decode results
    dec_info_u             dec_info;
    imm_fmt_e              imm_fmt;
    logic [INST_W-1:0]     imm;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic                  rd_we;

    inst_classify u_classify (
        .inst_i     (inst_i),
        .dec_info_o (dec_info),
        .imm_fmt_o  (imm_fmt),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rd_addr_o  (rd_addr),
        .rd_we_o    (rd_we)
    );

    imm_gen u_imm_gen (
        .inst_i    (inst_i),
        .imm_fmt_i (imm_fmt),
        .imm_o     (imm)
    );

    // capture stage, owns the handshake
    decode_hs_reg u_hs_reg (
        .clk        (clk),
        .rst_i      (rst_i),
        .req_i      (req_i),
        .dec_info_i (dec_info),
        .imm_i      (imm),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rd_addr_i  (rd_addr),
        .rd_we_i    (rd_we),
        .ack_o      (ack_o),
        .dec_info_o (dec_info_o),
        .imm_o      (imm_o),
        .rs1_addr_o (rs1_addr_o),
        .rs2_addr_o (rs2_addr_o),
        .rd_addr_o  (rd_addr_o),
        .rd_we_o    (rd_we_o)
    );

endmodule

/* logic/imm_gen.sv */
// RV32I immediate builder, combinational
// all layouts sign-extend from inst[31] except the 5-bit shamt
// IMM_NONE gives zero
`timescale 1ns/1ps

module imm_gen (
    input  logic [rv_decode_pkg::INST_W-1:0] inst_i,
    input  rv_decode_pkg::imm_fmt_e          imm_fmt_i,
    output logic [rv_decode_pkg::INST_W-1:0] imm_o
);
    import rv_decode_pkg::*;

    logic [INST_W-1:0] imm_i_type;
    logic [INST_W-1:0] imm_s_type;
    logic [INST_W-1:0] imm_b_type;
    logic [INST_W-1:0] imm_u_type;
    logic [INST_W-1:0] imm_j_type;
    logic [INST_W-1:0] imm_shamt;

    // loads, jalr, op-imm
    assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
    // store offset split around rs2
    assign imm_s_type = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    // branch offset, bit 0 always clear
    assign imm_b_type = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    // upper 20 bits, low 12 zero
    assign imm_u_type = {inst_i[31:12], 12'b0};
    // jal offset, bit 0 always clear
    assign imm_j_type = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    // shift amount, zero-extended
    assign imm_shamt  = {27'b0, inst_i[24:20]};

    always_comb begin
        case (imm_fmt_i)
            IMM_I:     imm_o = imm_i_type;
            IMM_S:     imm_o = imm_s_type;
            IMM_B:     imm_o = imm_b_type;
            IMM_U:     imm_o = imm_u_type;
            IMM_J:     imm_o = imm_j_type;
            IMM_SHIFT: imm_o = imm_shamt;
            default:   imm_o = '0;
        endcase
    end

endmodule

/* logic/inst_classify.sv */
// combinational RV32I classifier, zero latency
// anything outside the kept alu, branch/jump and load/store sets decodes
// to GRP_NONE with all register accesses and the format cleared
`timescale 1ns/1ps

module inst_classify (
    input  logic [rv_decode_pkg::INST_W-1:0]     inst_i,
    output rv_decode_pkg::dec_info_u             dec_info_o,
    output rv_decode_pkg::imm_fmt_e              imm_fmt_o,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] rd_addr_o,
    output logic                                 rd_we_o
);
    import rv_decode_pkg::*;

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    // one-hot funct3
    logic [7:0]            f3_dec;
    logic                  f7_base;
    logic                  f7_alt;

    // opcode matches
    logic is_lui;
    logic is_auipc;
    logic is_jal;
    logic is_jalr;
    logic is_branch;
    logic is_load;
    logic is_store;
    logic is_op_imm;
    logic is_op;

    // fully recognised instruction classes
    logic br_hit;
    logic ld_hit;
    logic st_hit;
    logic opi_shift;
    logic opi_hit;
    logic op_hit;
    logic rri_hit;
    logic alu_hit;
    logic bjp_hit;
    logic mem_hit;

    logic rs1_rd;
    logic rs2_rd;
    logic rd_wr;

    // instruction fields
    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];
    assign funct7 = inst_i[31:25];

    assign f3_dec  = 8'b1 << funct3;
    assign f7_base = (funct7 == F7_BASE);
    assign f7_alt  = (funct7 == F7_ALT);

    assign is_lui    = (opcode == OPC_LUI);
    assign is_auipc  = (opcode == OPC_AUIPC);
    assign is_jal    = (opcode == OPC_JAL);
    assign is_jalr   = (opcode == OPC_JALR) & f3_dec[0];
    assign is_branch = (opcode == OPC_BRANCH);
    assign is_load   = (opcode == OPC_LOAD);
    assign is_store  = (opcode == OPC_STORE);
    assign is_op_imm = (opcode == OPC_OP_IMM);
    assign is_op     = (opcode == OPC_OP);

    // branch funct3 2 and 3 are reserved
    assign br_hit = is_branch & ~f3_dec[2] & ~f3_dec[3];
    // lb lh lw lbu lhu
    assign ld_hit = is_load & (f3_dec[0] | f3_dec[1] | f3_dec[2] | f3_dec[4] | f3_dec[5]);
    // sb sh sw
    assign st_hit = is_store & (f3_dec[0] | f3_dec[1] | f3_dec[2]);

    // shift immediates keep funct7 in imm[11:5]
    assign opi_shift = is_op_imm & ((f3_dec[1] & f7_base) | (f3_dec[5] & (f7_base | f7_alt)));
    assign opi_hit   = opi_shift | (is_op_imm & ~f3_dec[1] & ~f3_dec[5]);
    // only add/sub and srl/sra accept the alternate funct7
    assign op_hit    = is_op & (f7_base | (f7_alt & (f3_dec[0] | f3_dec[5])));
    // reg-imm or reg-reg, funct3 names the same op in both
    assign rri_hit   = opi_hit | op_hit;

    assign alu_hit = is_lui | is_auipc | rri_hit;
    assign bjp_hit = is_jal | is_jalr | br_hit;
    assign mem_hit = ld_hit | st_hit;

    // decode word, one view per group
    always_comb begin
        dec_info_o = '0;
        if (alu_hit) begin
            dec_info_o.alu.grp    = GRP_ALU;
            dec_info_o.alu.lui    = is_lui;
            dec_info_o.alu.auipc  = is_auipc;
            // addi ignores funct7, add needs the base form
            dec_info_o.alu.add    = f3_dec[0] & (opi_hit | (op_hit & f7_base));
            dec_info_o.alu.sub    = op_hit & f3_dec[0] & f7_alt;
            dec_info_o.alu.sll    = rri_hit & f3_dec[1];
            dec_info_o.alu.slt    = rri_hit & f3_dec[2];
            dec_info_o.alu.sltu   = rri_hit & f3_dec[3];
            dec_info_o.alu.bxor   = rri_hit & f3_dec[4];
            dec_info_o.alu.srl    = rri_hit & f3_dec[5] & f7_base;
            dec_info_o.alu.sra    = rri_hit & f3_dec[5] & f7_alt;
            dec_info_o.alu.bor    = rri_hit & f3_dec[6];
            dec_info_o.alu.band   = rri_hit & f3_dec[7];
            dec_info_o.alu.op2imm = opi_hit | is_lui | is_auipc;
            dec_info_o.alu.op1pc  = is_auipc;
        end else if (bjp_hit) begin
            dec_info_o.bjp.grp    = GRP_BJP;
            dec_info_o.bjp.jump   = is_jal | is_jalr;
            dec_info_o.bjp.beq    = br_hit & f3_dec[0];
            dec_info_o.bjp.bne    = br_hit & f3_dec[1];
            dec_info_o.bjp.blt    = br_hit & f3_dec[4];
            dec_info_o.bjp.bge    = br_hit & f3_dec[5];
            dec_info_o.bjp.bltu   = br_hit & f3_dec[6];
            dec_info_o.bjp.bgeu   = br_hit & f3_dec[7];
            dec_info_o.bjp.op1rs1 = is_jalr;
        end else if (mem_hit) begin
            dec_info_o.mem.grp = GRP_MEM;
            dec_info_o.mem.lb  = ld_hit & f3_dec[0];
            dec_info_o.mem.lh  = ld_hit & f3_dec[1];
            dec_info_o.mem.lw  = ld_hit & f3_dec[2];
            dec_info_o.mem.lbu = ld_hit & f3_dec[4];
            dec_info_o.mem.lhu = ld_hit & f3_dec[5];
            dec_info_o.mem.sb  = st_hit & f3_dec[0];
            dec_info_o.mem.sh  = st_hit & f3_dec[1];
            dec_info_o.mem.sw  = st_hit & f3_dec[2];
        end
    end

    // register file access
    assign rs1_rd = (alu_hit | bjp_hit | mem_hit) & ~is_lui & ~is_auipc & ~is_jal;
    assign rs2_rd = op_hit | st_hit | br_hit;
    assign rd_wr  = is_lui | is_auipc | is_jal | is_jalr | ld_hit | opi_hit | op_hit;

    // unused addresses read as x0
    assign rs1_addr_o = rs1_rd ? rs1 : '0;
    assign rs2_addr_o = rs2_rd ? rs2 : '0;
    assign rd_addr_o  = rd_wr ? rd : '0;
    assign rd_we_o    = rd_wr;

    // immediate layout
    always_comb begin
        if (is_lui | is_auipc) begin
            imm_fmt_o = IMM_U;
        end else if (is_jal) begin
            imm_fmt_o = IMM_J;
        end else if (br_hit) begin
            imm_fmt_o = IMM_B;
        end else if (st_hit) begin
            imm_fmt_o = IMM_S;
        end else if (opi_shift) begin
            imm_fmt_o = IMM_SHIFT;
        end else if (ld_hit | is_jalr | opi_hit) begin
            imm_fmt_o = IMM_I;
        end else begin
            imm_fmt_o = IMM_NONE;
        end
    end

endmodule

/* logic/rv_decode_pkg.sv */
// shared encodings for the RV32I decode stage
// base integer set only; no M extension, CSR or system encodings
// decode word is 17 bits: 3-bit group code on top of a 14-bit flag field
package rv_decode_pkg;

    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 5;

    // major opcodes, inst[6:0]
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // funct7, normal form and sub/sra form
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    localparam int DEC_GRP_W     = 3;
    // flag field sized for the widest group (alu)
    localparam int DEC_PAYLOAD_W = 14;
    // bjp and mem carry 8 flags each, rest is padding
    localparam int DEC_PAD_W     = DEC_PAYLOAD_W - 8;

    typedef enum logic [DEC_GRP_W-1:0] {
        GRP_NONE = 3'd0,
        GRP_ALU  = 3'd1,
        GRP_BJP  = 3'd2,
        GRP_MEM  = 3'd3
    } grp_e;

    // immediate layout chosen by the classifier
    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_SHIFT
    } imm_fmt_e;

    // group code sits in the top bits of every view
    typedef struct packed {
        grp_e grp;
        logic lui;
        logic auipc;
        logic add;
        logic sub;
        logic sll;
        logic slt;
        logic sltu;
        // bitwise ops, named apart from the keywords
        logic bxor;
        logic srl;
        logic sra;
        logic bor;
        logic band;
        // op2 from immediate, op1 from pc
        logic op2imm;
        logic op1pc;
    } alu_info_t;

    typedef struct packed {
        grp_e                 grp;
        logic                 jump;
        logic                 beq;
        logic                 bne;
        logic                 blt;
        logic                 bge;
        logic                 bltu;
        logic                 bgeu;
        // jalr target base is rs1, not pc
        logic                 op1rs1;
        logic [DEC_PAD_W-1:0] pad;
    } bjp_info_t;

    typedef struct packed {
        grp_e                 grp;
        logic                 lb;
        logic                 lh;
        logic                 lw;
        logic                 lbu;
        logic                 lhu;
        logic                 sb;
        logic                 sh;
        logic                 sw;
        logic [DEC_PAD_W-1:0] pad;
    } mem_info_t;

    // read through the view named by grp
    // GRP_NONE means the whole word is zero
    typedef union packed {
        alu_info_t alu;
        bjp_info_t bjp;
        mem_info_t mem;
    } dec_info_u;

endpackage

/* run.sh */
#!/usr/bin/env bash
# builds the decode stage testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f compile.f \
    --top-module tb_decode_stage \
    -Mdir build \
    -o tb_decode_stage

./build/tb_decode_stage | tee sim.log

if grep -q '\*\*\* TEST FAILED \*\*\*' sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"

/* tests/tb_decode_stage.sv */
// testbench for the registered RV32I decode stage
// random instructions from a fixed seed are checked against a model of the decode rules
// run length bounded by a cycle counter sized from the transaction counts
`timescale 1ns/1ps

module tb_decode_stage;
    import rv_decode_pkg::*;

    localparam int N_ALU = 200;
    localparam int N_BJP = 150;
    localparam int N_MEM = 150;
    localparam int N_BAD = 100;
    localparam int CYCLE_LIMIT = 4 * (N_ALU + N_BJP + N_MEM + N_BAD) * 8;

    logic                  clk;
    logic                  rst_i;
    logic                  req_i;
    logic [INST_W-1:0]     inst_i;
    logic                  ack_o;
    dec_info_u             dec_info_o;
    logic [INST_W-1:0]     imm_o;
    logic [REG_ADDR_W-1:0] rs1_addr_o;
    logic [REG_ADDR_W-1:0] rs2_addr_o;
    logic [REG_ADDR_W-1:0] rd_addr_o;
    logic                  rd_we_o;

    int cycle_count  = 0;
    int hs_errs      = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    logic [INST_W-1:0] cur_inst;

    decode_stage UUT (
        .clk        (clk),
        .rst_i      (rst_i),
        .req_i      (req_i),
        .inst_i     (inst_i),
        .ack_o      (ack_o),
        .dec_info_o (dec_info_o),
        .imm_o      (imm_o),
        .rs1_addr_o (rs1_addr_o),
        .rs2_addr_o (rs2_addr_o),
        .rd_addr_o  (rd_addr_o),
        .rd_we_o    (rd_we_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // watchdog
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // alu operation flag from funct3 where alt picks sub or sra
    function automatic dec_info_u alu_flags(input dec_info_u base, input logic [2:0] f3,
                                            input logic alt);
        dec_info_u info;
        info = base;
        case (f3)
            3'd0: begin
                if (alt) info.alu.sub = 1'b1;
                else info.alu.add = 1'b1;
            end
            3'd1: info.alu.sll = 1'b1;
            3'd2: info.alu.slt = 1'b1;
            3'd3: info.alu.sltu = 1'b1;
            3'd4: info.alu.bxor = 1'b1;
            3'd5: begin
                if (alt) info.alu.sra = 1'b1;
                else info.alu.srl = 1'b1;
            end
            3'd6: info.alu.bor = 1'b1;
            default: info.alu.band = 1'b1;
        endcase
        return info;
    endfunction

    // reference model of the decode rules
    task automatic predict_decode(input logic [31:0] inst, output dec_info_u info,
                                  output logic [31:0] imm, output logic [4:0] rs1,
                                  output logic [4:0] rs2, output logic [4:0] rd,
                                  output logic we);
        logic [6:0]  opc;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [31:0] sx;
        logic        ok;
        logic        use1;
        logic        use2;
        opc  = inst[6:0];
        f3   = inst[14:12];
        f7   = inst[31:25];
        // sign fill shifted up past each layout's field
        sx   = {32{inst[31]}};
        info = '0;
        imm  = '0;
        use1 = 1'b0;
        use2 = 1'b0;
        we   = 1'b0;
        ok   = 1'b1;
        case (opc)
            OPC_LUI, OPC_AUIPC: begin
                info.alu.grp    = GRP_ALU;
                info.alu.lui    = (opc == OPC_LUI);
                info.alu.auipc  = (opc == OPC_AUIPC);
                info.alu.op2imm = 1'b1;
                info.alu.op1pc  = (opc == OPC_AUIPC);
                we  = 1'b1;
                imm = {inst[31:12], 12'h000};
            end
            OPC_OP_IMM: begin
                // shifts take funct7 from the immediate's top bits
                if (f3 == 3'd1) ok = (f7 == F7_BASE);
                if (f3 == 3'd5) ok = (f7 == F7_BASE) || (f7 == F7_ALT);
                if (ok) begin
                    info.alu.grp    = GRP_ALU;
                    info            = alu_flags(info, f3, (f3 == 3'd5) && (f7 == F7_ALT));
                    info.alu.op2imm = 1'b1;
                    use1 = 1'b1;
                    we   = 1'b1;
                    if (f3 == 3'd1 || f3 == 3'd5) imm = {27'd0, inst[24:20]};
                    else imm = (sx << 12) | {20'd0, inst[31:20]};
                end
            end
            OPC_OP: begin
                ok = (f7 == F7_BASE) || ((f7 == F7_ALT) && (f3 == 3'd0 || f3 == 3'd5));
                if (ok) begin
                    info.alu.grp = GRP_ALU;
                    info = alu_flags(info, f3, f7 == F7_ALT);
                    use1 = 1'b1;
                    use2 = 1'b1;
                    we   = 1'b1;
                end
            end
            OPC_JAL: begin
                info.bjp.grp  = GRP_BJP;
                info.bjp.jump = 1'b1;
                we  = 1'b1;
                imm = (sx << 20) | {12'd0, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            OPC_JALR: begin
                if (f3 == 3'd0) begin
                    info.bjp.grp    = GRP_BJP;
                    info.bjp.jump   = 1'b1;
                    info.bjp.op1rs1 = 1'b1;
                    use1 = 1'b1;
                    we   = 1'b1;
                    imm  = (sx << 12) | {20'd0, inst[31:20]};
                end
            end
            OPC_BRANCH: begin
                case (f3)
                    3'd0: info.bjp.beq = 1'b1;
                    3'd1: info.bjp.bne = 1'b1;
                    3'd4: info.bjp.blt = 1'b1;
                    3'd5: info.bjp.bge = 1'b1;
                    3'd6: info.bjp.bltu = 1'b1;
                    3'd7: info.bjp.bgeu = 1'b1;
                    default: ok = 1'b0;
                endcase
                if (ok) begin
                    info.bjp.grp = GRP_BJP;
                    use1 = 1'b1;
                    use2 = 1'b1;
                    imm  = (sx << 12) | {20'd0, inst[7], inst[30:25], inst[11:8], 1'b0};
                end
            end
            OPC_LOAD: begin
                case (f3)
                    3'd0: info.mem.lb = 1'b1;
                    3'd1: info.mem.lh = 1'b1;
                    3'd2: info.mem.lw = 1'b1;
                    3'd4: info.mem.lbu = 1'b1;
                    3'd5: info.mem.lhu = 1'b1;
                    default: ok = 1'b0;
                endcase
                if (ok) begin
                    info.mem.grp = GRP_MEM;
                    use1 = 1'b1;
                    we   = 1'b1;
                    imm  = (sx << 12) | {20'd0, inst[31:20]};
                end
            end
            OPC_STORE: begin
                case (f3)
                    3'd0: info.mem.sb = 1'b1;
                    3'd1: info.mem.sh = 1'b1;
                    3'd2: info.mem.sw = 1'b1;
                    default: ok = 1'b0;
                endcase
                if (ok) begin
                    info.mem.grp = GRP_MEM;
                    use1 = 1'b1;
                    use2 = 1'b1;
                    imm  = (sx << 12) | {20'd0, inst[31:25], inst[11:7]};
                end
            end
            default: ;
        endcase
        rs1 = use1 ? inst[19:15] : 5'd0;
        rs2 = use2 ? inst[24:20] : 5'd0;
        rd  = we ? inst[11:7] : 5'd0;
    endtask

    // lui, auipc, op and op-imm with both funct7 forms
    function automatic logic [31:0] random_alu_inst();
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12;
        int          pick;
        f3   = 3'($urandom_range(7, 0));
        pick = $urandom_range(9, 0);
        if (pick == 0) return {20'($urandom), 5'($urandom), OPC_LUI};
        if (pick == 1) return {20'($urandom), 5'($urandom), OPC_AUIPC};
        f7 = F7_BASE;
        if ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(1, 0) == 1) f7 = F7_ALT;
        if (pick < 6) return {f7, 5'($urandom), 5'($urandom), f3, 5'($urandom), OPC_OP};
        imm12 = 12'($urandom);
        // shift forms need a legal funct7 in imm[11:5]
        if (f3 == 3'd1 || f3 == 3'd5) imm12[11:5] = f7;
        return {imm12, 5'($urandom), f3, 5'($urandom), OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] random_bjp_inst();
        int idx;
        idx = $urandom_range(7, 0);
        if (idx == 0) return {20'($urandom), 5'($urandom), OPC_JAL};
        if (idx == 1) return {12'($urandom), 5'($urandom), 3'd0, 5'($urandom), OPC_JALR};
        // branch funct3 0,1,4,5,6,7
        idx = $urandom_range(5, 0);
        return {7'($urandom), 5'($urandom), 5'($urandom),
                (idx < 2) ? 3'(idx) : 3'(idx + 2), 5'($urandom), OPC_BRANCH};
    endfunction

    function automatic logic [31:0] random_mem_inst();
        int idx;
        if ($urandom_range(1, 0) == 0) begin
            // load funct3 0,1,2,4,5
            idx = $urandom_range(4, 0);
            return {12'($urandom), 5'($urandom), (idx < 3) ? 3'(idx) : 3'(idx + 1),
                    5'($urandom), OPC_LOAD};
        end
        return {7'($urandom), 5'($urandom), 5'($urandom), 3'($urandom_range(2, 0)),
                5'($urandom), OPC_STORE};
    endfunction

    // muldiv, csr/system, fence, bad funct7, reserved load funct3
    function automatic logic [31:0] random_bad_inst();
        int idx;
        case ($urandom_range(4, 0))
            0: return {7'h01, 5'($urandom), 5'($urandom), 3'($urandom), 5'($urandom), OPC_OP};
            1: return {25'($urandom), 7'b1110011};
            2: return {25'($urandom), 7'b0001111};
            3: begin
                // bit 1 set keeps it off both legal funct7 values
                return {7'($urandom) | 7'h02, 5'($urandom), 5'($urandom), 3'($urandom),
                        5'($urandom), OPC_OP};
            end
            default: begin
                idx = $urandom_range(2, 0);
                return {12'($urandom), 5'($urandom), (idx == 0) ? 3'd3 : 3'(idx + 5),
                        5'($urandom), OPC_LOAD};
            end
        endcase
    endfunction

    task automatic compare_outputs(input string name, input dec_info_u e_info,
                                   input logic [31:0] e_imm, input logic [4:0] e_rs1,
                                   input logic [4:0] e_rs2, input logic [4:0] e_rd,
                                   input logic e_we, output int errs);
        errs = 0;
        if (dec_info_o !== e_info) begin
            $display("[ERROR] %s inst %08h dec_info expected %05h actual %05h",
                     name, cur_inst, e_info, dec_info_o);
            errs++;
        end
        if (imm_o !== e_imm) begin
            $display("[ERROR] %s inst %08h imm expected %08h actual %08h",
                     name, cur_inst, e_imm, imm_o);
            errs++;
        end
        if (rs1_addr_o !== e_rs1) begin
            $display("[ERROR] %s inst %08h rs1_addr expected %0d actual %0d",
                     name, cur_inst, e_rs1, rs1_addr_o);
            errs++;
        end
        if (rs2_addr_o !== e_rs2) begin
            $display("[ERROR] %s inst %08h rs2_addr expected %0d actual %0d",
                     name, cur_inst, e_rs2, rs2_addr_o);
            errs++;
        end
        if (rd_addr_o !== e_rd) begin
            $display("[ERROR] %s inst %08h rd_addr expected %0d actual %0d",
                     name, cur_inst, e_rd, rd_addr_o);
            errs++;
        end
        if (rd_we_o !== e_we) begin
            $display("[ERROR] %s inst %08h rd_we expected %b actual %b",
                     name, cur_inst, e_we, rd_we_o);
            errs++;
        end
    endtask

    // one full four-phase handshake with checks at each phase
    task automatic send_instruction(input string name, input logic [31:0] inst,
                                    output int errs);
        dec_info_u   e_info;
        logic [31:0] e_imm;
        logic [4:0]  e_rs1;
        logic [4:0]  e_rs2;
        logic [4:0]  e_rd;
        logic        e_we;
        int          edges;
        int          extra;
        int          held_errs;
        predict_decode(inst, e_info, e_imm, e_rs1, e_rs2, e_rd, e_we);
        cur_inst = inst;
        @(posedge clk);
        inst_i <= inst;
        req_i  <= 1'b1;
        // count negedge samples until ack where 2 means one edge of latency
        edges = 0;
        do begin
            @(negedge clk);
            edges++;
        end while (ack_o !== 1'b1);
        if (edges != 2) begin
            $display("[ERROR] handshake ack_o rise latency expected 1 actual %0d", edges - 1);
            hs_errs++;
        end
        compare_outputs(name, e_info, e_imm, e_rs1, e_rs2, e_rd, e_we, errs);
        // slow requester scrambles inst_i while ack is high
        extra = $urandom_range(3, 0);
        repeat (extra) begin
            @(posedge clk);
            inst_i <= $urandom;
            @(negedge clk);
            if (ack_o !== 1'b1) begin
                $display("[ERROR] handshake ack_o while req_i held expected 1 actual %b", ack_o);
                hs_errs++;
            end
            compare_outputs("handshake", e_info, e_imm, e_rs1, e_rs2, e_rd, e_we, held_errs);
            hs_errs += held_errs;
        end
        @(posedge clk);
        req_i <= 1'b0;
        edges = 0;
        do begin
            @(negedge clk);
            edges++;
        end while (ack_o !== 1'b0);
        if (edges != 2) begin
            $display("[ERROR] handshake ack_o fall latency expected 1 actual %0d", edges - 1);
            hs_errs++;
        end
    endtask

    task automatic report_test(input string name, input int count, input int errs);
        if (errs == 0) begin
            $display("%s: %0d transactions, all outputs matched", name, count);
            tests_passed++;
        end else begin
            $display("%s: %0d transactions, %0d mismatches", name, count, errs);
            tests_failed++;
        end
    endtask

    task automatic run_group(input string name, input int kind, input int count);
        logic [31:0] inst;
        int          errs;
        int          total;
        total = 0;
        for (int n = 0; n < count; n++) begin
            case (kind)
                0: inst = random_alu_inst();
                1: inst = random_bjp_inst();
                2: inst = random_mem_inst();
                default: inst = random_bad_inst();
            endcase
            send_instruction(name, inst, errs);
            total += errs;
        end
        report_test(name, count, total);
    endtask

    initial begin
        int errs;
        rst_i    = 1'b1;
        req_i    = 1'b0;
        inst_i   = '0;
        cur_inst = '0;
        void'($urandom(32'h71ad));
        // ack and outputs low while reset is held
        repeat (2) begin
            @(negedge clk);
            compare_outputs("handshake", '0, '0, '0, '0, '0, 1'b0, errs);
            hs_errs += errs;
            if (ack_o !== 1'b0) begin
                $display("[ERROR] handshake ack_o during reset expected 0 actual %b", ack_o);
                hs_errs++;
            end
        end
        @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        compare_outputs("handshake", '0, '0, '0, '0, '0, 1'b0, errs);
        hs_errs += errs;
        if (ack_o !== 1'b0) begin
            $display("[ERROR] handshake ack_o after reset expected 0 actual %b", ack_o);
            hs_errs++;
        end

        run_group("alu_decode", 0, N_ALU);
        run_group("branch_jump_decode", 1, N_BJP);
        run_group("load_store_decode", 2, N_MEM);
        run_group("dropped_malformed", 3, N_BAD);
        report_test("handshake", N_ALU + N_BJP + N_MEM + N_BAD, hs_errs);

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
